/* sim/tb_l1_axi_bridge.sv */
/*
 * Testbench for the L1 to AXI4 bridge
 * Random cache requests against a randomly stalling AXI slave with its own
 * line storage, checked against a line memory model and a queue of
 * expected responses in request order
 */

`timescale 1ns/10ps
`default_nettype none

module tb_l1_axi_bridge
    import axi_pkg::*;
    import l1_mem_pkg::*;
;

    localparam int ADDR_BITS = 48;
    localparam int LINE_BITS = 256;
    localparam int STRB_BITS = LINE_BITS / 8;
    localparam int NUM_RAND  = 120;         // Mixed reads and writes
    localparam int NUM_LINES = 16;          // Final read-back of every line
    localparam int TIMEOUT   = 200;         // Cycles per wait
    localparam logic [ADDR_BITS-1:0] LINE_BASE = 48'h0000_4000_0000;

    typedef struct packed {
        logic                  write;
        logic                  cached;
        logic                  path;
        logic [2:0]            size;
        logic [ADDR_BITS-1:0]  addr;
        logic [STRB_BITS-1:0]  strb;
        logic [LINE_BITS-1:0]  data;
    } req_t;

    logic                        i_clk;
    logic                        i_nrst;
    logic                        i_req_valid;
    logic                        o_req_ready;
    logic                        i_req_path;
    logic [REQ_TYPE_BITS-1:0]    i_req_type;
    logic [AXI_SIZE_BITS-1:0]    i_req_size;
    logic [ADDR_BITS-1:0]        i_req_addr;
    logic [STRB_BITS-1:0]        i_req_strob;
    logic [LINE_BITS-1:0]        i_req_data;
    logic                        o_resp_valid;
    logic                        o_resp_path;
    logic [LINE_BITS-1:0]        o_resp_data;
    logic                        o_resp_load_fault;
    logic                        o_resp_store_fault;
    logic                        o_ar_valid;
    logic                        i_ar_ready;
    logic [ADDR_BITS-1:0]        o_ar_addr;
    logic [AXI_CACHE_BITS-1:0]   o_ar_cache;
    logic [AXI_SIZE_BITS-1:0]    o_ar_size;
    logic [AXI_PROT_BITS-1:0]    o_ar_prot;
    logic                        i_r_valid;
    logic                        o_r_ready;
    logic [LINE_BITS-1:0]        i_r_data;
    logic [AXI_RESP_BITS-1:0]    i_r_resp;
    logic                        i_r_last;
    logic                        o_aw_valid;
    logic                        i_aw_ready;
    logic [ADDR_BITS-1:0]        o_aw_addr;
    logic [AXI_CACHE_BITS-1:0]   o_aw_cache;
    logic [AXI_SIZE_BITS-1:0]    o_aw_size;
    logic [AXI_PROT_BITS-1:0]    o_aw_prot;
    logic                        o_w_valid;
    logic                        i_w_ready;
    logic [LINE_BITS-1:0]        o_w_data;
    logic [STRB_BITS-1:0]        o_w_strb;
    logic                        o_w_last;
    logic                        i_b_valid;
    logic                        o_b_ready;
    logic [AXI_RESP_BITS-1:0]    i_b_resp;

    int                    seed;
    req_t                  expect_q[$];              // Accepted but not yet answered
    logic [LINE_BITS-1:0]  model_mem[logic [ADDR_BITS-1:0]];
    logic [LINE_BITS-1:0]  slave_mem[logic [ADDR_BITS-1:0]];
    logic                  bus_busy;
    logic                  ar_hs, aw_hs, w_hs, r_hs, b_hs;
    logic                  rd_pend, wr_pend, aw_got, w_got, r_err, b_err;
    logic [2:0]            rd_wait, wr_wait;
    logic [ADDR_BITS-1:0]  rd_addr, wr_addr;
    logic [LINE_BITS-1:0]  wr_data;
    logic [STRB_BITS-1:0]  wr_strb;

    l1_axi_bridge #(
        .ADDR_BITS (ADDR_BITS),
        .LINE_BITS (LINE_BITS)
    ) u_dut (
        .i_clk (i_clk), .i_nrst (i_nrst),
        .i_req_valid (i_req_valid), .o_req_ready (o_req_ready),
        .i_req_path (i_req_path), .i_req_type (i_req_type),
        .i_req_size (i_req_size), .i_req_addr (i_req_addr),
        .i_req_strob (i_req_strob), .i_req_data (i_req_data),
        .o_resp_valid (o_resp_valid), .o_resp_path (o_resp_path),
        .o_resp_data (o_resp_data), .o_resp_load_fault (o_resp_load_fault),
        .o_resp_store_fault (o_resp_store_fault),
        .o_ar_valid (o_ar_valid), .i_ar_ready (i_ar_ready), .o_ar_addr (o_ar_addr),
        .o_ar_cache (o_ar_cache), .o_ar_size (o_ar_size), .o_ar_prot (o_ar_prot),
        .i_r_valid (i_r_valid), .o_r_ready (o_r_ready), .i_r_data (i_r_data),
        .i_r_resp (i_r_resp), .i_r_last (i_r_last),
        .o_aw_valid (o_aw_valid), .i_aw_ready (i_aw_ready), .o_aw_addr (o_aw_addr),
        .o_aw_cache (o_aw_cache), .o_aw_size (o_aw_size), .o_aw_prot (o_aw_prot),
        .o_w_valid (o_w_valid), .i_w_ready (i_w_ready), .o_w_data (o_w_data),
        .o_w_strb (o_w_strb), .o_w_last (o_w_last),
        .i_b_valid (i_b_valid), .o_b_ready (o_b_ready), .i_b_resp (i_b_resp)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    task automatic check(input string name, input logic [LINE_BITS-1:0] actual,
                         input logic [LINE_BITS-1:0] expected);
        if (actual !== expected) begin
            $display("Error: time %0t, %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_test(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // Unique contents of a line that was never written
    function automatic logic [LINE_BITS-1:0] line_fill(input logic [ADDR_BITS-1:0] addr);
        return {4{addr, addr[15:0] ^ 16'hC35A}};
    endfunction

    function automatic logic [LINE_BITS-1:0] merge_line(input logic [LINE_BITS-1:0] old_line,
                                                        input logic [LINE_BITS-1:0] new_line,
                                                        input logic [STRB_BITS-1:0] strb);
        logic [LINE_BITS-1:0] res;
        int                   b;
        res = old_line;
        for (b = 0; b < STRB_BITS; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_line[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [LINE_BITS-1:0] model_read(input logic [ADDR_BITS-1:0] addr);
        return model_mem.exists(addr) ? model_mem[addr] : line_fill(addr);
    endfunction

    function automatic logic [LINE_BITS-1:0] slave_read(input logic [ADDR_BITS-1:0] addr);
        return slave_mem.exists(addr) ? slave_mem[addr] : line_fill(addr);
    endfunction

    task automatic build_request(input int n, output req_t r);
        logic [31:0] rnd;
        int          k;
        rnd      = $random(seed);
        r.write  = (n < NUM_RAND) ? rnd[0] : 1'b0;
        r.cached = rnd[1];
        r.path   = rnd[2];
        r.size   = rnd[5:3];
        r.addr   = LINE_BASE + ((n < NUM_RAND) ? (rnd[9:6] << 5) : ((n - NUM_RAND) << 5));
        r.strb   = $random(seed);
        for (k = 0; k < LINE_BITS / 32; k++) begin
            r.data[k*32 +: 32] = $random(seed);
        end
    endtask

    task automatic drive_request(input req_t r);
        i_req_valid                 = 1'b1;
        i_req_path                  = r.path;
        i_req_type                  = '0;
        i_req_type[REQ_TYPE_WRITE]  = r.write;
        i_req_type[REQ_TYPE_CACHED] = r.cached;
        i_req_size                  = r.size;
        i_req_addr                  = r.addr;
        i_req_strob                 = r.strb;
        i_req_data                  = r.data;
    endtask

    // Sampled at the falling edge to flag the handshakes of the next rising edge
    task automatic observe_bus();
        req_t e;
        ar_hs = o_ar_valid & i_ar_ready;
        aw_hs = o_aw_valid & i_aw_ready;
        w_hs  = o_w_valid & i_w_ready;
        r_hs  = i_r_valid & o_r_ready;
        b_hs  = i_b_valid & o_b_ready;
        if ((o_ar_valid | o_aw_valid) && bus_busy)
            abort_test("Address channel raised before the previous response was returned");
        if (o_ar_valid | o_aw_valid | o_w_valid) begin
            if (expect_q.size() == 0) abort_test("AXI request seen with no accepted cache request");
            e = expect_q[0];
            if (o_ar_valid) begin
                check("o_ar_valid", o_ar_valid, !e.write);
                check("o_ar_addr", o_ar_addr, e.addr);
                check("o_ar_size", o_ar_size, e.size);
                check("o_ar_cache", o_ar_cache, e.cached ? 4'b1111 : 4'b0000);
                check("o_ar_prot", o_ar_prot, e.path ? 3'b100 : 3'b000);
            end
            if (o_aw_valid) begin
                check("o_aw_valid", o_aw_valid, e.write);
                check("o_aw_addr", o_aw_addr, e.addr);
                check("o_aw_size", o_aw_size, e.size);
                check("o_aw_cache", o_aw_cache, e.cached ? 4'b1111 : 4'b0000);
                check("o_aw_prot", o_aw_prot, e.path ? 3'b100 : 3'b000);
            end
            if (o_w_valid) begin
                check("o_w_valid", o_w_valid, e.write);
                check("o_w_data", o_w_data, e.data);
                check("o_w_strb", o_w_strb, e.strb);
                check("o_w_last", o_w_last, 1'b1);
            end
        end
        if (ar_hs | aw_hs) bus_busy = 1'b1;
        if (ar_hs) rd_addr = o_ar_addr;
        if (aw_hs) wr_addr = o_aw_addr;
        if (w_hs) begin
            wr_data = o_w_data;
            wr_strb = o_w_strb;
        end
        if (o_resp_valid) begin
            if (expect_q.size() == 0) abort_test("Response seen with no outstanding request");
            e        = expect_q.pop_front();
            bus_busy = 1'b0;
            check("o_resp_path", o_resp_path, e.path);
            if (e.write) begin
                check("o_resp_store_fault", o_resp_store_fault, b_err);
                check("o_resp_load_fault", o_resp_load_fault, 1'b0);
                if (!b_err) model_mem[e.addr] = merge_line(model_read(e.addr), e.data, e.strb);
            end else begin
                check("o_resp_load_fault", o_resp_load_fault, r_err);
                check("o_resp_store_fault", o_resp_store_fault, 1'b0);
                check("o_resp_data", o_resp_data, model_read(e.addr));
            end
        end
    endtask

    // AXI slave that updates its drives just after the rising edge
    task automatic slave_step();
        logic [31:0] rnd;
        rnd        = $random(seed);
        i_ar_ready = rnd[0];                // Independent stall per channel
        i_aw_ready = rnd[1];
        i_w_ready  = rnd[2];
        if (r_hs) begin
            i_r_valid = 1'b0;
            i_r_last  = 1'b0;
        end
        if (b_hs) begin
            i_b_valid = 1'b0;
            if (!b_err) slave_mem[wr_addr] = merge_line(slave_read(wr_addr), wr_data, wr_strb);
            aw_got = 1'b0;
            w_got  = 1'b0;
        end
        if (ar_hs) begin
            rd_pend = 1'b1;
            rd_wait = rnd[6:4];
        end
        if (aw_hs) aw_got = 1'b1;
        if (w_hs) w_got = 1'b1;
        if ((aw_hs | w_hs) && aw_got && w_got) begin
            wr_pend = 1'b1;
            wr_wait = rnd[9:7];
        end
        if (rd_pend) begin
            if (rd_wait == 0) begin
                rd_pend   = 1'b0;
                r_err     = (rnd[12:10] == 0);  // SLVERR on about one in eight
                i_r_valid = 1'b1;
                i_r_last  = 1'b1;
                i_r_data  = slave_read(rd_addr);
                i_r_resp  = r_err ? 2'b10 : 2'b00;
            end else begin
                rd_wait = rd_wait - 1;
            end
        end
        if (wr_pend) begin
            if (wr_wait == 0) begin
                wr_pend   = 1'b0;
                b_err     = (rnd[15:13] == 0);
                i_b_valid = 1'b1;
                i_b_resp  = b_err ? 2'b10 : 2'b00;
            end else begin
                wr_wait = wr_wait - 1;
            end
        end
    endtask

    initial begin
        {i_ar_ready, i_aw_ready, i_w_ready, i_r_valid, i_r_last, i_b_valid} = '0;
        i_r_data = '0;
        i_r_resp = '0;
        i_b_resp = '0;
        {bus_busy, ar_hs, aw_hs, w_hs, r_hs, b_hs} = '0;
        {rd_pend, wr_pend, aw_got, w_got, r_err, b_err} = '0;
        forever begin
            @(negedge i_clk);
            observe_bus();
            @(posedge i_clk);
            #1;
            slave_step();
        end
    end

    initial begin
        req_t cur;
        req_t nxt;
        int   n;
        int   t;
        seed        = 56;
        i_nrst      = 1'b0;
        i_req_valid = 1'b0;
        i_req_path  = 1'b0;
        i_req_type  = '0;
        i_req_size  = '0;
        i_req_addr  = '0;
        i_req_strob = '0;
        i_req_data  = '0;
        repeat (2) @(posedge i_clk);
        #1 i_nrst = 1'b1;
        @(negedge i_clk);
        check("o_req_ready", o_req_ready, 1'b1);
        check("o_ar_valid", o_ar_valid, 1'b0);
        check("o_aw_valid", o_aw_valid, 1'b0);
        check("o_w_valid", o_w_valid, 1'b0);
        check("o_r_ready", o_r_ready, 1'b0);
        check("o_b_ready", o_b_ready, 1'b0);
        check("o_resp_valid", o_resp_valid, 1'b0);
        build_request(0, cur);
        @(posedge i_clk);
        #1 drive_request(cur);
        for (n = 0; n < NUM_RAND + NUM_LINES; n++) begin
            t = 0;
            @(negedge i_clk);
            while (!o_req_ready) begin
                t++;
                if (t > TIMEOUT) abort_test("Timeout: request was never accepted");
                @(negedge i_clk);
            end
            if (n + 1 < NUM_RAND + NUM_LINES) build_request(n + 1, nxt);
            @(posedge i_clk);
            #1;
            expect_q.push_back(cur);
            if (n + 1 < NUM_RAND + NUM_LINES) begin
                drive_request(nxt);         // Back-to-back requests
                cur = nxt;
            end else begin
                i_req_valid = 1'b0;
            end
        end
        t = 0;
        while (expect_q.size() != 0) begin
            t++;
            if (t > TIMEOUT) abort_test("Timeout: responses missing at the end of the run");
            @(negedge i_clk);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/axi_pkg.sv
verilog/l1_mem_pkg.sv
verilog/l1_req_decode.sv
verilog/axi_issue.sv
verilog/axi_resp_collect.sv
verilog/l1_axi_bridge.sv
sim/tb_l1_axi_bridge.sv

/* verilog/axi_issue.sv */
/*
 * AXI address and write-data sequencer
 * Owns the transaction in flight. Drives AR for reads, or AW and W for
 * writes with independent acceptance, then waits for the response
 */

`timescale 1ns/10ps
`default_nettype none

module axi_issue
    import axi_pkg::*;
#(
    parameter int ADDR_BITS = 48,
    parameter int LINE_BITS = 256
) (
    input  wire                        i_clk,
    input  wire                        i_nrst,
    input  wire                        i_cmd_valid,
    input  wire                        i_cmd_write,
    input  wire                        i_cmd_path,
    input  wire [ADDR_BITS-1:0]        i_cmd_addr,
    input  wire [AXI_SIZE_BITS-1:0]    i_cmd_size,
    input  wire [AXI_CACHE_BITS-1:0]   i_cmd_cache,
    input  wire [AXI_PROT_BITS-1:0]    i_cmd_prot,
    input  wire [LINE_BITS-1:0]        i_cmd_wdata,
    input  wire [LINE_BITS/8-1:0]      i_cmd_wstrb,
    output logic                       o_cmd_take,
    output logic                       o_ar_valid,
    input  wire                        i_ar_ready,
    output logic [ADDR_BITS-1:0]       o_ar_addr,
    output logic [AXI_CACHE_BITS-1:0]  o_ar_cache,
    output logic [AXI_SIZE_BITS-1:0]   o_ar_size,
    output logic [AXI_PROT_BITS-1:0]   o_ar_prot,
    output logic                       o_aw_valid,
    input  wire                        i_aw_ready,
    output logic [ADDR_BITS-1:0]       o_aw_addr,
    output logic [AXI_CACHE_BITS-1:0]  o_aw_cache,
    output logic [AXI_SIZE_BITS-1:0]   o_aw_size,
    output logic [AXI_PROT_BITS-1:0]   o_aw_prot,
    output logic                       o_w_valid,
    input  wire                        i_w_ready,
    output logic [LINE_BITS-1:0]       o_w_data,
    output logic [LINE_BITS/8-1:0]     o_w_strb,
    output logic                       o_w_last,
    output logic                       o_issued_rd,
    output logic                       o_issued_wr,
    output logic                       o_issued_path,
    input  wire                        i_txn_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,        // AR, or AW and W together
        ST_WRITE,       // One of AW/W accepted, other still pending
        ST_WAIT         // Response outstanding
    } state_t;

    state_t                     state;
    state_t                     state_nxt;
    logic                       aw_done;
    logic                       w_done;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       wr_phase;
    logic                       wr_r;
    logic                       path_r;
    logic [ADDR_BITS-1:0]       addr_r;
    logic [AXI_SIZE_BITS-1:0]   size_r;
    logic [AXI_CACHE_BITS-1:0]  cache_r;
    logic [AXI_PROT_BITS-1:0]   prot_r;

    assign o_cmd_take = (state == ST_IDLE) & i_cmd_valid;
    assign wr_phase   = wr_r & ((state == ST_ADDR) | (state == ST_WRITE));

    assign o_ar_valid = (state == ST_ADDR) & ~wr_r;
    assign o_aw_valid = wr_phase & ~aw_done;
    assign o_w_valid  = wr_phase & ~w_done;
    assign o_w_last   = o_w_valid;                          // Single beat per line
    assign aw_fire    = o_aw_valid & i_aw_ready;
    assign w_fire     = o_w_valid & i_w_ready;

    assign o_issued_rd   = o_ar_valid & i_ar_ready;
    assign o_issued_wr   = wr_phase & (aw_done | aw_fire) & (w_done | w_fire);
    assign o_issued_path = path_r;

    // Same attributes on both address channels
    assign o_ar_addr  = addr_r;
    assign o_ar_cache = cache_r;
    assign o_ar_size  = size_r;
    assign o_ar_prot  = prot_r;
    assign o_aw_addr  = addr_r;
    assign o_aw_cache = cache_r;
    assign o_aw_size  = size_r;
    assign o_aw_prot  = prot_r;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (o_cmd_take) state_nxt = ST_ADDR;
            ST_ADDR: begin
                if (o_issued_rd | o_issued_wr) begin
                    state_nxt = ST_WAIT;
                end else if (aw_fire | w_fire) begin
                    state_nxt = ST_WRITE;
                end
            end
            ST_WRITE: if (o_issued_wr) state_nxt = ST_WAIT;
            ST_WAIT:  if (i_txn_done) state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (o_cmd_take) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                aw_done <= aw_done | aw_fire;
                w_done  <= w_done | w_fire;
            end
        end
    end

    // Command copy
    always_ff @(posedge i_clk) begin
        if (o_cmd_take) begin
            wr_r     <= i_cmd_write;
            path_r   <= i_cmd_path;
            addr_r   <= i_cmd_addr;
            size_r   <= i_cmd_size;
            cache_r  <= i_cmd_cache;
            prot_r   <= i_cmd_prot;
            o_w_data <= i_cmd_wdata;
            o_w_strb <= i_cmd_wstrb;
        end
    end

endmodule

`default_nettype wire

/* verilog/axi_pkg.sv */
/*
 * AXI4 master definitions for the L1 bridge
 * Channel field widths, AxCACHE attribute codes and the response error bit
 */

`default_nettype none

package axi_pkg;

    // Field widths
    localparam int AXI_CACHE_BITS = 4;
    localparam int AXI_PROT_BITS  = 3;
    localparam int AXI_SIZE_BITS  = 3;
    localparam int AXI_RESP_BITS  = 2;

    // Set for SLVERR and DECERR
    localparam int AXI_RESP_ERR_BIT = 1;

    // Read attributes
    localparam logic [AXI_CACHE_BITS-1:0] ARCACHE_WRBACK_READ_ALLOCATE  = 4'b1111;
    localparam logic [AXI_CACHE_BITS-1:0] ARCACHE_DEVICE_NON_BUFFERABLE = 4'b0000;

    // Write attributes
    localparam logic [AXI_CACHE_BITS-1:0] AWCACHE_WRBACK_WRITE_ALLOCATE = 4'b1111;
    localparam logic [AXI_CACHE_BITS-1:0] AWCACHE_DEVICE_NON_BUFFERABLE = 4'b0000;

endpackage

`default_nettype wire

/* verilog/axi_resp_collect.sv */
/*
 * AXI response collector
 * Waits on R or B for the issued transaction and turns the final beat
 * into one cache-side response with the load or store fault
 */

`timescale 1ns/10ps
`default_nettype none

module axi_resp_collect
    import axi_pkg::*;
    import l1_mem_pkg::*;
#(
    parameter int LINE_BITS = 256
) (
    input  wire                        i_clk,
    input  wire                        i_nrst,
    input  wire                        i_issued_rd,
    input  wire                        i_issued_wr,
    input  wire                        i_issued_path,
    input  wire                        i_r_valid,
    output logic                       o_r_ready,
    input  wire [LINE_BITS-1:0]        i_r_data,
    input  wire [AXI_RESP_BITS-1:0]    i_r_resp,
    input  wire                        i_r_last,
    input  wire                        i_b_valid,
    output logic                       o_b_ready,
    input  wire [AXI_RESP_BITS-1:0]    i_b_resp,
    output logic                       o_resp_valid,
    output logic                       o_resp_path,
    output logic [LINE_BITS-1:0]       o_resp_data,
    output logic                       o_resp_load_fault,
    output logic                       o_resp_store_fault,
    output logic                       o_txn_done
);

    logic exp_rd;
    logic exp_wr;
    logic r_end;
    logic b_end;

    assign o_r_ready = exp_rd;
    assign o_b_ready = exp_wr;

    assign r_end = exp_rd & i_r_valid & i_r_last;          // Last R beat closes a read
    assign b_end = exp_wr & i_b_valid;

    assign o_resp_valid       = r_end | b_end;
    assign o_resp_data        = i_r_data;
    assign o_resp_load_fault  = r_end & i_r_resp[AXI_RESP_ERR_BIT];
    assign o_resp_store_fault = b_end & i_b_resp[AXI_RESP_ERR_BIT];
    assign o_txn_done         = o_resp_valid;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            exp_rd      <= 1'b0;
            exp_wr      <= 1'b0;
            o_resp_path <= PATH_DATA;
        end else if (i_issued_rd | i_issued_wr) begin
            exp_rd      <= i_issued_rd;
            exp_wr      <= i_issued_wr;
            o_resp_path <= i_issued_path;
        end else if (o_txn_done) begin
            exp_rd <= 1'b0;
            exp_wr <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/l1_axi_bridge.sv */
/*
 * L1 to AXI4 bridge
 * Takes one line request at a time from the cache memory port, runs it
 * as a single-beat AXI read or write and returns one response per request
 * One more request may wait in the decoder while the bus is busy
 */

`timescale 1ns/10ps
`default_nettype none

module l1_axi_bridge
    import axi_pkg::*;
    import l1_mem_pkg::*;
#(
    parameter int ADDR_BITS = 48,
    parameter int LINE_BITS = 256
) (
    input  wire                        i_clk,
    input  wire                        i_nrst,
    // Cache request
    input  wire                        i_req_valid,
    output logic                       o_req_ready,
    input  wire                        i_req_path,
    input  wire [REQ_TYPE_BITS-1:0]    i_req_type,
    input  wire [AXI_SIZE_BITS-1:0]    i_req_size,
    input  wire [ADDR_BITS-1:0]        i_req_addr,
    input  wire [LINE_BITS/8-1:0]      i_req_strob,
    input  wire [LINE_BITS-1:0]        i_req_data,
    // Cache response
    output logic                       o_resp_valid,
    output logic                       o_resp_path,
    output logic [LINE_BITS-1:0]       o_resp_data,
    output logic                       o_resp_load_fault,
    output logic                       o_resp_store_fault,
    // AR channel
    output logic                       o_ar_valid,
    input  wire                        i_ar_ready,
    output logic [ADDR_BITS-1:0]       o_ar_addr,
    output logic [AXI_CACHE_BITS-1:0]  o_ar_cache,
    output logic [AXI_SIZE_BITS-1:0]   o_ar_size,
    output logic [AXI_PROT_BITS-1:0]   o_ar_prot,
    // R channel
    input  wire                        i_r_valid,
    output logic                       o_r_ready,
    input  wire [LINE_BITS-1:0]        i_r_data,
    input  wire [AXI_RESP_BITS-1:0]    i_r_resp,
    input  wire                        i_r_last,
    // AW channel
    output logic                       o_aw_valid,
    input  wire                        i_aw_ready,
    output logic [ADDR_BITS-1:0]       o_aw_addr,
    output logic [AXI_CACHE_BITS-1:0]  o_aw_cache,
    output logic [AXI_SIZE_BITS-1:0]   o_aw_size,
    output logic [AXI_PROT_BITS-1:0]   o_aw_prot,
    // W channel
    output logic                       o_w_valid,
    input  wire                        i_w_ready,
    output logic [LINE_BITS-1:0]       o_w_data,
    output logic [LINE_BITS/8-1:0]     o_w_strb,
    output logic                       o_w_last,
    // B channel
    input  wire                        i_b_valid,
    output logic                       o_b_ready,
    input  wire [AXI_RESP_BITS-1:0]    i_b_resp
);

    localparam int STRB_BITS = LINE_BITS / 8;

    // Decoder to issuer
    logic                       cmd_valid;
    logic                       cmd_take;
    logic                       cmd_write;
    logic                       cmd_path;
    logic [ADDR_BITS-1:0]       cmd_addr;
    logic [AXI_SIZE_BITS-1:0]   cmd_size;
    logic [AXI_CACHE_BITS-1:0]  cmd_cache;
    logic [AXI_PROT_BITS-1:0]   cmd_prot;
    logic [LINE_BITS-1:0]       cmd_wdata;
    logic [STRB_BITS-1:0]       cmd_wstrb;

    // Issuer to collector
    logic                       issued_rd;
    logic                       issued_wr;
    logic                       issued_path;
    logic                       txn_done;

    l1_req_decode #(
        .ADDR_BITS (ADDR_BITS),
        .LINE_BITS (LINE_BITS)
    ) u_decode (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req_path  (i_req_path),
        .i_req_type  (i_req_type),
        .i_req_size  (i_req_size),
        .i_req_addr  (i_req_addr),
        .i_req_strob (i_req_strob),
        .i_req_data  (i_req_data),
        .i_cmd_take  (cmd_take),
        .o_cmd_valid (cmd_valid),
        .o_cmd_write (cmd_write),
        .o_cmd_path  (cmd_path),
        .o_cmd_addr  (cmd_addr),
        .o_cmd_size  (cmd_size),
        .o_cmd_cache (cmd_cache),
        .o_cmd_prot  (cmd_prot),
        .o_cmd_wdata (cmd_wdata),
        .o_cmd_wstrb (cmd_wstrb)
    );

    axi_issue #(
        .ADDR_BITS (ADDR_BITS),
        .LINE_BITS (LINE_BITS)
    ) u_issue (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_cmd_valid   (cmd_valid),
        .i_cmd_write   (cmd_write),
        .i_cmd_path    (cmd_path),
        .i_cmd_addr    (cmd_addr),
        .i_cmd_size    (cmd_size),
        .i_cmd_cache   (cmd_cache),
        .i_cmd_prot    (cmd_prot),
        .i_cmd_wdata   (cmd_wdata),
        .i_cmd_wstrb   (cmd_wstrb),
        .o_cmd_take    (cmd_take),
        .o_ar_valid    (o_ar_valid),
        .i_ar_ready    (i_ar_ready),
        .o_ar_addr     (o_ar_addr),
        .o_ar_cache    (o_ar_cache),
        .o_ar_size     (o_ar_size),
        .o_ar_prot     (o_ar_prot),
        .o_aw_valid    (o_aw_valid),
        .i_aw_ready    (i_aw_ready),
        .o_aw_addr     (o_aw_addr),
        .o_aw_cache    (o_aw_cache),
        .o_aw_size     (o_aw_size),
        .o_aw_prot     (o_aw_prot),
        .o_w_valid     (o_w_valid),
        .i_w_ready     (i_w_ready),
        .o_w_data      (o_w_data),
        .o_w_strb      (o_w_strb),
        .o_w_last      (o_w_last),
        .o_issued_rd   (issued_rd),
        .o_issued_wr   (issued_wr),
        .o_issued_path (issued_path),
        .i_txn_done    (txn_done)
    );

    axi_resp_collect #(
        .LINE_BITS (LINE_BITS)
    ) u_resp (
        .i_clk              (i_clk),
        .i_nrst             (i_nrst),
        .i_issued_rd        (issued_rd),
        .i_issued_wr        (issued_wr),
        .i_issued_path      (issued_path),
        .i_r_valid          (i_r_valid),
        .o_r_ready          (o_r_ready),
        .i_r_data           (i_r_data),
        .i_r_resp           (i_r_resp),
        .i_r_last           (i_r_last),
        .i_b_valid          (i_b_valid),
        .o_b_ready          (o_b_ready),
        .i_b_resp           (i_b_resp),
        .o_resp_valid       (o_resp_valid),
        .o_resp_path        (o_resp_path),
        .o_resp_data        (o_resp_data),
        .o_resp_load_fault  (o_resp_load_fault),
        .o_resp_store_fault (o_resp_store_fault),
        .o_txn_done         (txn_done)
    );

endmodule

`default_nettype wire

/* verilog/l1_mem_pkg.sv */
/*
 * L1 cache memory port definitions
 * Request type bit positions, path encoding and the AxPROT bit
 * derived from the path
 */

`default_nettype none

package l1_mem_pkg;

    // Request type vector
    localparam int REQ_TYPE_BITS   = 2;
    localparam int REQ_TYPE_WRITE  = 0;   // 1 = store / line write
    localparam int REQ_TYPE_CACHED = 1;   // 0 = device access

    // Requesting path
    localparam logic PATH_DATA  = 1'b0;
    localparam logic PATH_INSTR = 1'b1;

    // AxPROT[2] marks an instruction fetch
    // Bits 0 and 1 stay zero (unprivileged, secure)
    localparam int PROT_INSTR_BIT = 2;

endpackage

`default_nettype wire

/* verilog/l1_req_decode.sv */
/*
 * L1 request decoder
 * One-entry holding register for a cache line request. Classifies it as
 * read or write, cached or device, and derives AxCACHE and AxPROT
 */

`timescale 1ns/10ps
`default_nettype none

module l1_req_decode
    import axi_pkg::*;
    import l1_mem_pkg::*;
#(
    parameter int ADDR_BITS = 48,
    parameter int LINE_BITS = 256
) (
    input  wire                        i_clk,
    input  wire                        i_nrst,
    input  wire                        i_req_valid,
    output logic                       o_req_ready,
    input  wire                        i_req_path,
    input  wire [REQ_TYPE_BITS-1:0]    i_req_type,
    input  wire [AXI_SIZE_BITS-1:0]    i_req_size,
    input  wire [ADDR_BITS-1:0]        i_req_addr,
    input  wire [LINE_BITS/8-1:0]      i_req_strob,
    input  wire [LINE_BITS-1:0]        i_req_data,
    input  wire                        i_cmd_take,
    output logic                       o_cmd_valid,
    output logic                       o_cmd_write,
    output logic                       o_cmd_path,
    output logic [ADDR_BITS-1:0]       o_cmd_addr,
    output logic [AXI_SIZE_BITS-1:0]   o_cmd_size,
    output logic [AXI_CACHE_BITS-1:0]  o_cmd_cache,
    output logic [AXI_PROT_BITS-1:0]   o_cmd_prot,
    output logic [LINE_BITS-1:0]       o_cmd_wdata,
    output logic [LINE_BITS/8-1:0]     o_cmd_wstrb
);

    localparam int STRB_BITS = LINE_BITS / 8;

    logic                       req_fire;
    logic                       req_write;
    logic                       req_cached;
    logic [AXI_CACHE_BITS-1:0]  req_cache;
    logic [AXI_PROT_BITS-1:0]   req_prot;

    assign o_req_ready = ~o_cmd_valid;                      // Ready whenever the entry is empty
    assign req_fire    = i_req_valid & o_req_ready;
    assign req_write   = i_req_type[REQ_TYPE_WRITE];
    assign req_cached  = i_req_type[REQ_TYPE_CACHED];

    always_comb begin
        if (req_write) begin
            req_cache = req_cached ? AWCACHE_WRBACK_WRITE_ALLOCATE : AWCACHE_DEVICE_NON_BUFFERABLE;
        end else begin
            req_cache = req_cached ? ARCACHE_WRBACK_READ_ALLOCATE : ARCACHE_DEVICE_NON_BUFFERABLE;
        end
        req_prot = '0;
        req_prot[PROT_INSTR_BIT] = (i_req_path == PATH_INSTR);
    end

    // Entry occupancy, never set and cleared in the same cycle
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_cmd_valid <= 1'b0;
        end else if (req_fire) begin
            o_cmd_valid <= 1'b1;
        end else if (i_cmd_take) begin
            o_cmd_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            o_cmd_write <= req_write;
            o_cmd_path  <= i_req_path;
            o_cmd_addr  <= i_req_addr;
            o_cmd_size  <= i_req_size;
            o_cmd_cache <= req_cache;
            o_cmd_prot  <= req_prot;
            o_cmd_wdata <= req_write ? i_req_data : '0;      // Reads carry no data
            o_cmd_wstrb <= req_write ? i_req_strob : {STRB_BITS{1'b0}};
        end
    end

endmodule

`default_nettype wire
